//--- src.f
src/feature_pkg.sv
src/row_mem_if.sv
src/line_buf_if.sv
src/row_mem.sv
src/line_buffer.sv
src/gaussian_blur.sv
src/keypoint_detect.sv
src/core_ctrl.sv
src/feature_core.sv
dv/kpt_checker.sv
dv/tb_feature_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_feature_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_feature_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_feature_core
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
);
    localparam int NPIX       = IMG_W * IMG_H;
    localparam int RAW        = $clog2(IMG_H);
    localparam int KAW        = $clog2(NPIX);
    localparam int NUM_RUNS   = 8;
    localparam int RUN_CYCLES = IMG_H * (IMG_W + 8) + (IMG_H + 4) + (NPIX + 4);
    localparam int LIMIT_NS   = 2 * NUM_RUNS * RUN_CYCLES * 100 + 2000;   // double margin

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic                       filter_on;
    thres_t                     filter_threshold;
    logic                       load_we;
    logic [RAW-1:0]             load_addr;
    pix_t [IMG_W-1:0]           load_row;
    logic [KAW-1:0]             kpt_rd_addr;
    logic                       busy;
    logic                       done;
    logic [$clog2(NPIX+1)-1:0]  kpt_count;
    kpt_t                       kpt_rd_data;
    int                         value_errors;
    int                         protocol_errors;
    int                         timeouts = 0;
    int                         seed;
    logic                       waiting_done;
    thres_t                     sweep [4] = '{4'd0, 4'd3, 4'd8, 4'd15};

    feature_core #(.IMG_W(IMG_W), .IMG_H(IMG_H)) feature_core_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .load_we          (load_we),
        .load_addr        (load_addr),
        .load_row         (load_row),
        .kpt_rd_addr      (kpt_rd_addr),
        .busy             (busy),
        .done             (done),
        .kpt_count        (kpt_count),
        .kpt_rd_data      (kpt_rd_data)
    );

    kpt_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H)) kpt_checker_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .load_we          (load_we),
        .load_addr        (load_addr),
        .load_row         (load_row),
        .kpt_rd_addr      (kpt_rd_addr),
        .busy             (busy),
        .done             (done),
        .kpt_count        (kpt_count),
        .kpt_rd_data      (kpt_rd_data),
        .value_errors     (value_errors),
        .protocol_errors  (protocol_errors)
    );

    always #50 clk = ~clk;

    task automatic report_and_finish();
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic load_image(input logic random_fill, input pix_t level);
        for (int r = 0; r < IMG_H; r++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = RAW'(r);
            for (int c = 0; c < IMG_W; c++) begin
                load_row[c] = random_fill ? pix_t'($random(seed)) : level;
            end
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic wait_done();
        waiting_done = 1'b1;
        do begin
            @(negedge clk);
        end while (!done);
        waiting_done = 1'b0;
    endtask

    task automatic run_core(input logic on, input thres_t thr, input logic stray_start);
        @(negedge clk);
        filter_on        = on;
        filter_threshold = thr;
        start            = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (stray_start) begin
            repeat (5) @(negedge clk);
            filter_on        = 1'b1;   // a recapture would change the count
            filter_threshold = 4'hf;
            start            = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_done();
    endtask

    // starts in the done cycle, one address per cycle
    task automatic read_keypoints();
        int n;
        n = int'(kpt_count);
        for (int i = 0; i < n; i++) begin
            kpt_rd_addr = KAW'(i);
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        #(LIMIT_NS);
        timeouts++;
        if (waiting_done) begin
            $display("timeout at %0t ns: done never came after start", $time);
        end else begin
            $display("timeout at %0t ns: the test sequence did not finish", $time);
        end
        report_and_finish();
    end

    initial begin
        seed             = 32'hff03_2816;
        clk              = 1'b0;
        rst_n            = 1'b0;
        start            = 1'b0;
        filter_on        = 1'b0;
        filter_threshold = '0;
        load_we          = 1'b0;
        load_addr        = '0;
        load_row         = '0;
        kpt_rd_addr      = '0;
        waiting_done     = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);   // idle outputs before any start
        load_image(1'b0, 8'hb4);   // flat picture, only borders differ
        run_core(1'b0, 4'd0, 1'b0);
        read_keypoints();
        load_image(1'b1, 8'h00);
        run_core(1'b0, 4'd0, 1'b0);
        read_keypoints();
        for (int i = 0; i < 4; i++) begin
            run_core(1'b1, sweep[i], 1'b0);   // same picture, rising threshold
            read_keypoints();
        end
        load_image(1'b1, 8'h00);
        run_core(1'b0, 4'd0, 1'b1);
        read_keypoints();
        load_image(1'b1, 8'h00);
        run_core(1'b1, 4'd2, 1'b0);
        read_keypoints();
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- dv/kpt_checker.sv
`timescale 1ns/1ns
`default_nettype none

module kpt_checker
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    input  wire logic                                 filter_on,
    input  wire thres_t                               filter_threshold,
    input  wire logic                                 load_we,
    input  wire logic [$clog2(IMG_H)-1:0]             load_addr,
    input  wire pix_t [IMG_W-1:0]                     load_row,
    input  wire logic [$clog2(IMG_W * IMG_H)-1:0]     kpt_rd_addr,
    input  wire logic                                 busy,
    input  wire logic                                 done,
    input  wire logic [$clog2(IMG_W * IMG_H + 1)-1:0] kpt_count,
    input  wire kpt_t                                 kpt_rd_data,
    output int                                        value_errors,
    output int                                        protocol_errors
);
    localparam int NPIX = IMG_W * IMG_H;

    pix_t img [IMG_H][IMG_W];   // shadow of the image memory
    kpt_t exp_kpt [NPIX];
    int   exp_count;
    int   prev_count;
    int   rd_index;
    pix_t cur_thres;
    pix_t prev_thres;
    logic started;
    logic running;
    logic results_valid;
    logic just_started;
    logic image_changed;
    logic same_image;
    logic have_prev;
    logic rd_pending;
    logic done_q;

    function automatic pix_t pixel_at(int r, int c);
        if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
            return '0;   // outside the picture
        end
        return img[r][c];
    endfunction

    function automatic pix_t blurred(int r, int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w   = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);   // 1-2-1 / 2-4-2 / 1-2-1
                sum += w * int'(pixel_at(r + dr, c + dc));
            end
        end
        return pix_t'(sum / 16);
    endfunction

    // fills exp_kpt in raster order, returns the count
    function automatic int expected_keypoints(pix_t thr);
        int n;
        int d;
        n = 0;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                d = int'(img[r][c]) - int'(blurred(r, c));
                if (d < 0) begin
                    d = -d;
                end
                if (d > int'(thr)) begin
                    exp_kpt[n].row = KPT_COORD_W'(r);
                    exp_kpt[n].col = KPT_COORD_W'(c);
                    n++;
                end
            end
        end
        return n;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            value_errors    = 0;
            protocol_errors = 0;
            started         = 1'b0;
            running         = 1'b0;
            results_valid   = 1'b0;
            just_started    = 1'b0;
            image_changed   = 1'b0;
            have_prev       = 1'b0;
            rd_pending      = 1'b0;
            done_q          = 1'b0;
        end else begin
            if (rd_pending && kpt_rd_data !== exp_kpt[rd_index]) begin
                value_errors++;
                $display("[ERROR] %0t: keypoint %0d is (%0d,%0d), expected (%0d,%0d)", $time,
                         rd_index, kpt_rd_data.row, kpt_rd_data.col,
                         exp_kpt[rd_index].row, exp_kpt[rd_index].col);
            end
            rd_pending = 1'b0;
            if (!started && (busy || done || kpt_count != 0)) begin
                value_errors++;
                $display("[ERROR] %0t: before any start busy=%0b done=%0b kpt_count=%0d",
                         $time, busy, done, kpt_count);
            end
            if (just_started && (!busy || kpt_count != 0)) begin
                value_errors++;
                $display("[ERROR] %0t: after start busy=%0b kpt_count=%0d, expected 1 and 0",
                         $time, busy, kpt_count);
            end
            just_started = 1'b0;
            if (load_we && busy) begin
                protocol_errors++;
                $display("at %0t ns image row %0d was written while the core was busy",
                         $time, load_addr);
            end else if (load_we) begin
                for (int c = 0; c < IMG_W; c++) begin
                    img[load_addr][c] = load_row[c];
                end
                image_changed = 1'b1;
            end
            if (done) begin
                if (!running) begin
                    protocol_errors++;
                    $display("at %0t ns done pulsed with no run in progress", $time);
                end else if (kpt_count != exp_count) begin
                    value_errors++;
                    $display("[ERROR] %0t: kpt_count %0d, expected %0d",
                             $time, kpt_count, exp_count);
                end
                if (busy) begin
                    value_errors++;
                    $display("[ERROR] %0t: busy=1 in the done cycle, expected 0", $time);
                end
                if (done_q) begin
                    protocol_errors++;
                    $display("at %0t ns done stayed high for more than one cycle", $time);
                end
                if (have_prev && same_image && cur_thres >= prev_thres && kpt_count > prev_count)
                begin
                    value_errors++;
                    $display("[ERROR] %0t: count rose from %0d to %0d at threshold %0d",
                             $time, prev_count, kpt_count, cur_thres);
                end
                prev_thres    = cur_thres;
                prev_count    = int'(kpt_count);
                have_prev     = 1'b1;
                running       = 1'b0;
                results_valid = 1'b1;
            end
            done_q = done;
            if (start && !busy) begin
                started       = 1'b1;
                running       = 1'b1;
                results_valid = 1'b0;
                just_started  = 1'b1;
                cur_thres     = filter_on ? pix_t'(int'(filter_threshold) << THRES_SHIFT) : '0;
                same_image    = !image_changed;
                image_changed = 1'b0;
                exp_count     = expected_keypoints(cur_thres);
            end else if (!busy && results_valid && kpt_rd_addr < exp_count) begin
                rd_pending = 1'b1;   // data arrives next cycle
                rd_index   = int'(kpt_rd_addr);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/feature_core.sv
`timescale 1ns/1ns
`default_nettype none

module feature_core
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    input  wire logic                                 filter_on,
    input  wire thres_t                               filter_threshold,
    input  wire logic                                 load_we,
    input  wire logic [$clog2(IMG_H)-1:0]             load_addr,
    input  wire pix_t [IMG_W-1:0]                     load_row,   // element c is column c
    input  wire logic [$clog2(IMG_W * IMG_H)-1:0]     kpt_rd_addr,
    output logic                                      busy,
    output logic                                      done,
    output logic [$clog2(IMG_W * IMG_H + 1)-1:0]      kpt_count,
    output kpt_t                                      kpt_rd_data
);
    localparam int KPT_DEPTH = IMG_W * IMG_H;   // one entry per pixel at most

    typedef pix_t [IMG_W-1:0] row_t;

    logic                               blur_go;
    logic                               blur_fin;
    logic                               det_go;
    logic                               det_fin;
    pix_t                               thres;
    logic [$clog2(KPT_DEPTH + 1)-1:0]   det_num;

    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     img_mem_if ();
    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     blur_mem_if ();
    row_mem_if #(.payload_t(kpt_t), .DEPTH(KPT_DEPTH)) kpt_mem_if ();
    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     blur_img_rd_if ();
    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     blur_wr_if ();
    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     det_img_rd_if ();
    row_mem_if #(.payload_t(row_t), .DEPTH(IMG_H))     det_blur_rd_if ();
    row_mem_if #(.payload_t(kpt_t), .DEPTH(KPT_DEPTH)) det_kpt_wr_if ();
    line_buf_if #(.row_t(row_t))                       lb_if ();

    core_ctrl #(.IMG_W(IMG_W), .IMG_H(IMG_H)) core_ctrl_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .busy             (busy),
        .done             (done),
        .kpt_count        (kpt_count),
        .load_we          (load_we),
        .load_addr        (load_addr),
        .load_row         (load_row),
        .kpt_rd_addr      (kpt_rd_addr),
        .kpt_rd_data      (kpt_rd_data),
        .blur_go          (blur_go),
        .blur_fin         (blur_fin),
        .det_go           (det_go),
        .det_fin          (det_fin),
        .thres            (thres),
        .det_num          (det_num),
        .blur_img_rd      (blur_img_rd_if),
        .det_img_rd       (det_img_rd_if),
        .blur_wr          (blur_wr_if),
        .det_blur_rd      (det_blur_rd_if),
        .det_kpt_wr       (det_kpt_wr_if),
        .img_mem          (img_mem_if),
        .blur_mem         (blur_mem_if),
        .kpt_mem          (kpt_mem_if)
    );

    gaussian_blur #(.IMG_W(IMG_W), .IMG_H(IMG_H)) gaussian_blur_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .go      (blur_go),
        .fin     (blur_fin),
        .img_rd  (blur_img_rd_if),
        .blur_wr (blur_wr_if),
        .lb      (lb_if)
    );

    line_buffer #(.IMG_W(IMG_W)) line_buffer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .lb    (lb_if)
    );

    keypoint_detect #(.IMG_W(IMG_W), .IMG_H(IMG_H)) keypoint_detect_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .go      (det_go),
        .thres   (thres),
        .fin     (det_fin),
        .kpt_num (det_num),
        .img_rd  (det_img_rd_if),
        .blur_rd (det_blur_rd_if),
        .kpt_wr  (det_kpt_wr_if)
    );

    row_mem #(.payload_t(row_t), .DEPTH(IMG_H)) img_mem_inst (
        .clk  (clk),
        .port (img_mem_if)
    );

    row_mem #(.payload_t(row_t), .DEPTH(IMG_H)) blur_mem_inst (
        .clk  (clk),
        .port (blur_mem_if)
    );

    row_mem #(.payload_t(kpt_t), .DEPTH(KPT_DEPTH)) kpt_mem_inst (
        .clk  (clk),
        .port (kpt_mem_if)
    );

endmodule

`default_nettype wire

//--- src/core_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module core_ctrl
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 start,
    input  wire logic                                 filter_on,
    input  wire thres_t                               filter_threshold,
    output logic                                      busy,
    output logic                                      done,
    output logic [$clog2(IMG_W * IMG_H + 1)-1:0]      kpt_count,
    input  wire logic                                 load_we,
    input  wire logic [$clog2(IMG_H)-1:0]             load_addr,
    input  wire pix_t [IMG_W-1:0]                     load_row,
    input  wire logic [$clog2(IMG_W * IMG_H)-1:0]     kpt_rd_addr,
    output kpt_t                                      kpt_rd_data,
    output logic                                      blur_go,
    input  wire logic                                 blur_fin,
    output logic                                      det_go,
    input  wire logic                                 det_fin,
    output pix_t                                      thres,
    input  wire logic [$clog2(IMG_W * IMG_H + 1)-1:0] det_num,
    row_mem_if.memory                                 blur_img_rd,
    row_mem_if.memory                                 det_img_rd,
    row_mem_if.memory                                 blur_wr,
    row_mem_if.memory                                 det_blur_rd,
    row_mem_if.memory                                 det_kpt_wr,
    row_mem_if.requester                              img_mem,
    row_mem_if.requester                              blur_mem,
    row_mem_if.requester                              kpt_mem
);
    phase_t phase;

    assign busy = (phase != PH_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            blur_go   <= 1'b0;
            det_go    <= 1'b0;
            done      <= 1'b0;
            thres     <= '0;
            kpt_count <= '0;
        end else begin
            blur_go <= 1'b0;
            det_go  <= 1'b0;
            done    <= (phase == PH_FINISH);   // lands on the first idle cycle
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase     <= PH_BLUR;
                        blur_go   <= 1'b1;
                        kpt_count <= '0;
                        thres     <= filter_on ? pix_t'(filter_threshold) << THRES_SHIFT : '0;
                    end
                end
                PH_BLUR: begin
                    if (blur_fin) begin
                        phase  <= PH_DETECT;
                        det_go <= 1'b1;
                    end
                end
                PH_DETECT: begin
                    if (det_fin) begin
                        phase     <= PH_FINISH;
                        kpt_count <= det_num;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // port grant by phase, idle belongs to load and readback
    always_comb begin
        img_mem.we    = 1'b0;
        img_mem.addr  = load_addr;
        img_mem.din   = load_row;
        blur_mem.we   = 1'b0;
        blur_mem.addr = blur_wr.addr;
        blur_mem.din  = blur_wr.din;
        kpt_mem.we    = 1'b0;
        kpt_mem.addr  = kpt_rd_addr;
        kpt_mem.din   = det_kpt_wr.din;
        case (phase)
            PH_IDLE: img_mem.we = load_we;
            PH_BLUR: begin
                img_mem.we   = blur_img_rd.we;
                img_mem.addr = blur_img_rd.addr;
                img_mem.din  = blur_img_rd.din;
                blur_mem.we  = blur_wr.we;
            end
            PH_DETECT: begin
                img_mem.we    = det_img_rd.we;
                img_mem.addr  = det_img_rd.addr;
                img_mem.din   = det_img_rd.din;
                blur_mem.we   = det_blur_rd.we;
                blur_mem.addr = det_blur_rd.addr;
                blur_mem.din  = det_blur_rd.din;
                kpt_mem.we    = det_kpt_wr.we;
                kpt_mem.addr  = det_kpt_wr.addr;
            end
            default: ;
        endcase
    end

    assign blur_img_rd.dout = img_mem.dout;
    assign det_img_rd.dout  = img_mem.dout;
    assign blur_wr.dout     = blur_mem.dout;
    assign det_blur_rd.dout = blur_mem.dout;
    assign det_kpt_wr.dout  = kpt_mem.dout;
    assign kpt_rd_data      = kpt_mem.dout;

    assert property (@(posedge clk) disable iff (!rst_n) blur_fin |-> phase == PH_BLUR)
        else $error("blur fin outside blur phase");
    assert property (@(posedge clk) disable iff (!rst_n) det_fin |-> phase == PH_DETECT)
        else $error("detect fin outside detect phase");

endmodule

`default_nettype wire

//--- src/keypoint_detect.sv
`timescale 1ns/1ns
`default_nettype none

module keypoint_detect
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 go,
    input  wire pix_t                                 thres,
    output logic                                      fin,
    output logic [$clog2(IMG_W * IMG_H + 1)-1:0]      kpt_num,
    row_mem_if.requester                              img_rd,
    row_mem_if.requester                              blur_rd,
    row_mem_if.requester                              kpt_wr
);
    localparam int RAW = $clog2(IMG_H);
    localparam int CW  = $clog2(IMG_W);
    localparam int KAW = $clog2(IMG_W * IMG_H);

    typedef enum logic [1:0] {S_IDLE, S_RD, S_SCAN} state_t;

    state_t         state;
    logic [RAW-1:0] row;
    logic [CW-1:0]  col;
    pix_t           org;
    pix_t           blr;
    pix_t           diff;
    logic           hit;
    logic           last_col;
    logic           last_row;
    kpt_t           entry;

    assign org      = img_rd.dout[col];
    assign blr      = blur_rd.dout[col];
    assign diff     = (org > blr) ? org - blr : blr - org;
    assign hit      = (state == S_SCAN) && (diff > thres);
    assign last_col = (col == CW'(IMG_W - 1));
    assign last_row = (row == RAW'(IMG_H - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            row     <= '0;
            col     <= '0;
            kpt_num <= '0;
            fin     <= 1'b0;
        end else begin
            fin <= (state == S_SCAN) && last_col && last_row;   // after the last count update
            if (hit) begin
                kpt_num <= kpt_num + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state   <= S_RD;
                        row     <= '0;
                        col     <= '0;
                        kpt_num <= '0;
                    end
                end
                S_RD: state <= S_SCAN;
                default: begin
                    col <= col + 1'b1;
                    if (last_col) begin
                        col <= '0;
                        if (last_row) begin
                            state <= S_IDLE;
                        end else begin
                            row   <= row + 1'b1;
                            state <= S_RD;
                        end
                    end
                end
            endcase
        end
    end

    assign entry.row = KPT_COORD_W'(row);
    assign entry.col = KPT_COORD_W'(col);

    // both rows stay addressed for the whole scan
    assign img_rd.we    = 1'b0;
    assign img_rd.din   = '0;
    assign img_rd.addr  = row;
    assign blur_rd.we   = 1'b0;
    assign blur_rd.din  = '0;
    assign blur_rd.addr = row;
    assign kpt_wr.we    = hit;
    assign kpt_wr.addr  = kpt_num[KAW-1:0];
    assign kpt_wr.din   = entry;

    assert property (@(posedge clk) disable iff (!rst_n) kpt_num <= IMG_W * IMG_H)
        else $error("keypoint index %0d past memory depth", kpt_num);

endmodule

`default_nettype wire

//--- src/gaussian_blur.sv
`timescale 1ns/1ns
`default_nettype none

module gaussian_blur
    import feature_pkg::*;
#(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     go,
    output logic          fin,
    row_mem_if.requester  img_rd,
    row_mem_if.requester  blur_wr,
    line_buf_if.engine    lb
);
    localparam int RAW = $clog2(IMG_H);
    localparam int SW  = $clog2(IMG_H + 2);

    typedef enum logic [1:0] {S_IDLE, S_RD, S_SH, S_WR} state_t;
    typedef pix_t [IMG_W-1:0] row_t;

    state_t        state;
    logic [SW-1:0] step;       // index of the current line-buffer shift
    logic [SW-1:0] img_row;
    logic [SW-1:0] wr_row;
    logic          edge_row;   // shift before row 0 or after the last row
    logic [9:0]    vsum [IMG_W+2];
    row_t          blur_row;

    assign edge_row = (step == '0) || (step == SW'(IMG_H + 1));
    assign img_row  = step - 1'b1;
    assign wr_row   = step - 2'd2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state <= S_RD;
                        step  <= '0;
                    end
                end
                S_RD: state <= S_SH;   // memory latency
                S_SH: begin
                    if (step >= SW'(2)) begin
                        state <= S_WR;
                    end else begin
                        step  <= step + 1'b1;
                        state <= S_RD;
                    end
                end
                default: begin
                    if (step == SW'(IMG_H + 1)) begin
                        state <= S_IDLE;
                    end else begin
                        step  <= step + 1'b1;
                        state <= S_RD;
                    end
                end
            endcase
        end
    end

    // column sums first, then the horizontal 1-2-1
    always_comb begin
        logic [11:0] hsum;
        vsum[0]         = '0;
        vsum[IMG_W + 1] = '0;
        for (int c = 0; c < IMG_W; c++) begin
            vsum[c + 1] = 10'(lb.upper[c]) + {lb.middle[c], 1'b0} + 10'(lb.lower[c]);
        end
        for (int c = 0; c < IMG_W; c++) begin
            hsum        = 12'(vsum[c]) + {vsum[c + 1], 1'b0} + 12'(vsum[c + 2]);
            blur_row[c] = hsum[11:4];   // divide by 16, truncated
        end
    end

    assign img_rd.we    = 1'b0;
    assign img_rd.din   = '0;
    assign img_rd.addr  = edge_row ? '0 : img_row[RAW-1:0];
    assign lb.shift     = (state == S_SH);
    assign lb.fill_zero = edge_row;
    assign lb.row_in    = img_rd.dout;
    assign blur_wr.we   = (state == S_WR);
    assign blur_wr.addr = wr_row[RAW-1:0];
    assign blur_wr.din  = blur_row;
    assign fin          = (state == S_WR) && (step == SW'(IMG_H + 1));

    assert property (@(posedge clk) disable iff (!rst_n) blur_wr.we |-> wr_row < SW'(IMG_H))
        else $error("blur write to row %0d", wr_row);

endmodule

`default_nettype wire

//--- src/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer
    import feature_pkg::*;
#(
    parameter int IMG_W = 16
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    line_buf_if.buffer  lb
);
    pix_t [IMG_W-1:0] rows [3];   // 0 is the upper row

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows[0] <= '0;
            rows[1] <= '0;
            rows[2] <= '0;
        end else if (lb.shift) begin
            rows[0] <= rows[1];
            rows[1] <= rows[2];
            rows[2] <= lb.fill_zero ? '0 : lb.row_in;
        end
    end

    assign lb.upper  = rows[0];
    assign lb.middle = rows[1];
    assign lb.lower  = rows[2];

endmodule

`default_nettype wire

//--- src/row_mem.sv
`timescale 1ns/1ns
`default_nettype none

module row_mem #(
    parameter type payload_t = logic [127:0],
    parameter int  DEPTH     = 12
) (
    input  wire logic  clk,
    row_mem_if.memory  port
);
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.din;
        end
        port.dout <= mem[port.addr];   // read before write
    end

    assert property (@(posedge clk) port.we |-> port.addr < DEPTH)
        else $error("row_mem write beyond depth %0d", DEPTH);

endmodule

`default_nettype wire

//--- src/line_buf_if.sv
`timescale 1ns/1ns
`default_nettype none

interface line_buf_if #(
    parameter type row_t = logic [127:0]
);
    logic shift;
    logic fill_zero;   // load a zero row instead of row_in
    row_t row_in;
    row_t upper;
    row_t middle;
    row_t lower;

    modport engine (output shift, fill_zero, row_in, input upper, middle, lower);
    modport buffer (input shift, fill_zero, row_in, output upper, middle, lower);
endinterface

`default_nettype wire

//--- src/row_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface row_mem_if #(
    parameter type payload_t = logic [127:0],
    parameter int  DEPTH     = 12
);
    logic                     we;
    logic [$clog2(DEPTH)-1:0] addr;
    payload_t                 din;
    payload_t                 dout;   // word at last cycle's addr

    modport requester (output we, addr, din, input dout);
    modport memory    (input we, addr, din, output dout);
endinterface

`default_nettype wire

//--- src/feature_pkg.sv
`default_nettype none

package feature_pkg;

    localparam int PIX_W       = 8;
    localparam int THRES_SHIFT = 2;   // effective threshold fits in 6 bits
    localparam int KPT_COORD_W = 8;

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [3:0]       thres_t;

    typedef struct packed {
        logic [KPT_COORD_W-1:0] row;
        logic [KPT_COORD_W-1:0] col;
    } kpt_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_BLUR,
        PH_DETECT,
        PH_FINISH
    } phase_t;

endpackage

`default_nettype wire
